// File: source/cpu_macros.svh
/*
  core constants: reset PC, HALT encoding,
  register count
*/
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define PC_INIT    32'h0000_0000
`define HALT_INSTR 32'hffff_ffff

// architectural registers
`define NUM_REGS   32

`endif

// File: source/cpuTypesPkg.sv
/*
  core-wide types: data words and register indices,
  opcode and funct encodings, ALU operations, control
  levels and the payload held by each pipeline register
*/
package cpuTypesPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regBits_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
  } aluOp_t;

  typedef struct packed {
    logic   regDst, aluSrc, zeroExt, shiftSel, lui, wen;
    logic   dREN, dWEN, branch, bne, jmp, jal;
    aluOp_t aluOp;
  } ctrl_t;

  // stage register payloads
  typedef struct packed {
    word_t instr;
    word_t pcPlus4;
  } ifid_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    instr, pcPlus4, rdat1, rdat2;
    regBits_t dest;
  } idex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu, store, pcPlus4, instr;
    regBits_t dest;
  } exmem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu, load, pcPlus4, instr;
    regBits_t dest;
  } memwb_t;

endpackage

// File: source/fetchUnit.sv
/*
  instruction fetch: program counter, next-PC select
  and the IF/ID register
*/
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetchUnit import cpuTypesPkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  pipeEn,
  input  logic  stall,
  input  logic  redirect,
  input  word_t target,
  input  word_t imemload,
  output word_t imemaddr,
  output word_t ifidInstr,
  output word_t ifidPcPlus4
);
  word_t pc;
  word_t pcPlus4;
  ifid_t ifid;

  assign pcPlus4  = pc + 32'd4;
  assign imemaddr = pc;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc   <= `PC_INIT;
      ifid <= '0;
    end
    else if (pipeEn) begin
      if (redirect) begin
        pc   <= target;
        ifid <= '0;  // squash wrong-path fetch
      end
      else if (!stall) begin
        pc   <= pcPlus4;
        ifid <= '{instr: imemload, pcPlus4: pcPlus4};
      end
      // stalled: hold pc and IF/ID
    end
  end

  assign ifidInstr   = ifid.instr;
  assign ifidPcPlus4 = ifid.pcPlus4;

  // branch and jump targets keep the pc word aligned
  assert property (@(posedge CLK) disable iff (!nRST) pc[1:0] == 2'b00);

endmodule

// File: source/registerFile.sv
/*
  integer register file, two read ports and one write
  port, write-through on read, register zero fixed at 0
*/
`timescale 1ns/1ps
`include "cpu_macros.svh"

module registerFile import cpuTypesPkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regBits_t wsel,
  input  word_t    wdat,
  input  regBits_t rsel1,
  input  regBits_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);
  word_t regs [`NUM_REGS];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      regs <= '{default: '0};
    else if (wen && wsel != '0)
      regs[wsel] <= wdat;
  end

  // same-cycle write seen by decode
  assign rdat1 = (rsel1 == '0) ? '0 :
                 (wen && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 :
                 (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// File: source/controlDecoder.sv
/*
  main control: opcode and funct to control levels
*/
`timescale 1ns/1ps

module controlDecoder import cpuTypesPkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  always_comb begin
    ctrl = '0;  // unknown encodings fall through as NOP
    case (opcode_t'(instr[31:26]))
      OP_RTYPE: begin
        ctrl.regDst = 1'b1;
        ctrl.wen    = 1'b1;
        case (funct_t'(instr[5:0]))
          FN_ADDU: ctrl.aluOp = ALU_ADD;
          FN_SUBU: ctrl.aluOp = ALU_SUB;
          FN_AND:  ctrl.aluOp = ALU_AND;
          FN_OR:   ctrl.aluOp = ALU_OR;
          FN_SLT:  ctrl.aluOp = ALU_SLT;
          FN_SLL: begin
            ctrl.aluOp    = ALU_SLL;
            ctrl.shiftSel = 1'b1;  // shamt field as operand
          end
          default: ctrl = '0;
        endcase
      end
      OP_ADDIU, OP_LW, OP_SW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = ALU_ADD;
        ctrl.wen    = (opcode_t'(instr[31:26]) != OP_SW);
        ctrl.dREN   = (opcode_t'(instr[31:26]) == OP_LW);
        ctrl.dWEN   = (opcode_t'(instr[31:26]) == OP_SW);
      end
      OP_ORI: begin
        ctrl.aluSrc  = 1'b1;
        ctrl.zeroExt = 1'b1;
        ctrl.aluOp   = ALU_OR;
        ctrl.wen     = 1'b1;
      end
      OP_LUI: begin
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = ALU_LUI;
        ctrl.lui    = 1'b1;
        ctrl.wen    = 1'b1;
      end
      OP_BEQ, OP_BNE: begin
        ctrl.branch = 1'b1;
        ctrl.bne    = (opcode_t'(instr[31:26]) == OP_BNE);
      end
      OP_J:    ctrl.jmp = 1'b1;
      OP_JAL: begin
        ctrl.jmp = 1'b1;
        ctrl.jal = 1'b1;
        ctrl.wen = 1'b1;  // link into r31
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// File: source/decodeUnit.sv
/*
  decode stage: register read, destination select,
  load-use hazard detection and the ID/EX register
*/
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeUnit import cpuTypesPkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     pipeEn,
  input  logic     flush,
  input  word_t    ifidInstr,
  input  word_t    ifidPcPlus4,
  input  logic     wen,
  input  regBits_t wsel,
  input  word_t    wdat,
  output logic     stall,
  output ctrl_t    idexCtrl,
  output word_t    idexInstr,
  output word_t    idexPcPlus4,
  output word_t    idexRdat1,
  output word_t    idexRdat2,
  output regBits_t idexDest
);
  ctrl_t    ctrl;
  regBits_t rs, rt, rd, dest;
  word_t    rdat1, rdat2;
  idex_t    idex;

  assign rs = ifidInstr[25:21];
  assign rt = ifidInstr[20:16];
  assign rd = ifidInstr[15:11];

  controlDecoder ctrlDec_i (.instr(ifidInstr), .ctrl(ctrl));

  registerFile regFile_i (
    .CLK(CLK), .nRST(nRST), .wen(wen), .wsel(wsel), .wdat(wdat),
    .rsel1(rs), .rsel2(rt), .rdat1(rdat1), .rdat2(rdat2)
  );

  // JAL links into the last register
  assign dest = ctrl.jal ? regBits_t'(`NUM_REGS - 1) : (ctrl.regDst ? rd : rt);

  // load in EX whose result is needed here
  assign stall = idex.ctrl.dREN && idex.dest != '0 && (idex.dest == rs || idex.dest == rt);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      idex <= '0;
    else if (pipeEn) begin
      if (flush || stall)
        idex <= '0;  // bubble
      else
        idex <= '{ctrl: ctrl, instr: ifidInstr, pcPlus4: ifidPcPlus4,
                   rdat1: rdat1, rdat2: rdat2, dest: dest};
    end
  end

  assign idexCtrl    = idex.ctrl;
  assign idexInstr   = idex.instr;
  assign idexPcPlus4 = idex.pcPlus4;
  assign idexRdat1   = idex.rdat1;
  assign idexRdat2   = idex.rdat2;
  assign idexDest    = idex.dest;

  // a redirecting instruction in EX is never a load
  assert property (@(posedge CLK) disable iff (!nRST) pipeEn |-> !(stall && flush));

endmodule

// File: source/executeUnit.sv
/*
  execute stage: operand forwarding, immediate extend,
  ALU, branch and jump resolution, EX/MEM register
*/
`timescale 1ns/1ps

module executeUnit import cpuTypesPkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     pipeEn,
  input  logic     dhit,
  input  ctrl_t    idexCtrl,
  input  word_t    idexInstr,
  input  word_t    idexPcPlus4,
  input  word_t    idexRdat1,
  input  word_t    idexRdat2,
  input  regBits_t idexDest,
  input  logic     memwbWen,
  input  regBits_t memwbDest,
  input  word_t    memwbValue,
  output logic     redirect,
  output word_t    target,
  output ctrl_t    exmemCtrl,
  output word_t    exmemAlu,
  output word_t    exmemStore,
  output word_t    exmemPcPlus4,
  output word_t    exmemInstr,
  output regBits_t exmemDest
);
  exmem_t   exmem;
  regBits_t rs, rt;
  word_t    exmemValue, fwdA, fwdB, imm, opA, opB, aluOut;
  logic     taken;

  assign rs = idexInstr[25:21];
  assign rt = idexInstr[20:16];

  // result EX/MEM will write, link value for JAL
  assign exmemValue = exmem.ctrl.jal ? exmem.pcPlus4 : exmem.alu;

  always_comb begin
    fwdA = idexRdat1;
    fwdB = idexRdat2;
    if (exmem.ctrl.wen && exmem.dest != '0 && exmem.dest == rs)
      fwdA = exmemValue;  // newest first
    else if (memwbWen && memwbDest != '0 && memwbDest == rs)
      fwdA = memwbValue;
    if (exmem.ctrl.wen && exmem.dest != '0 && exmem.dest == rt)
      fwdB = exmemValue;
    else if (memwbWen && memwbDest != '0 && memwbDest == rt)
      fwdB = memwbValue;
  end

  assign imm = idexCtrl.zeroExt ? {16'h0, idexInstr[15:0]}
                                : {{16{idexInstr[15]}}, idexInstr[15:0]};

  // SLL shifts rt by shamt
  assign opA = idexCtrl.shiftSel ? fwdB : fwdA;
  assign opB = idexCtrl.shiftSel ? {27'd0, idexInstr[10:6]} : (idexCtrl.aluSrc ? imm : fwdB);

  always_comb begin
    case (idexCtrl.aluOp)
      ALU_ADD: aluOut = opA + opB;
      ALU_SUB: aluOut = opA - opB;
      ALU_AND: aluOut = opA & opB;
      ALU_OR:  aluOut = opA | opB;
      ALU_SLT: aluOut = {31'd0, $signed(opA) < $signed(opB)};
      ALU_SLL: aluOut = opA << opB[4:0];
      ALU_LUI: aluOut = {opB[15:0], 16'h0};
      default: aluOut = '0;
    endcase
  end

  assign taken    = idexCtrl.branch && ((fwdA == fwdB) != idexCtrl.bne);
  assign redirect = idexCtrl.jmp || taken;
  assign target   = idexCtrl.jmp ? {idexPcPlus4[31:28], idexInstr[25:0], 2'b00}
                                 : idexPcPlus4 + {imm[29:0], 2'b00};

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      exmem <= '0;
    else if (pipeEn)
      exmem <= '{ctrl: idexCtrl, alu: aluOut, store: fwdB, pcPlus4: idexPcPlus4,
                 instr: idexInstr, dest: idexDest};
    else if (dhit)
      exmem <= '0;  // data access done, free the stage
  end

  assign exmemCtrl    = exmem.ctrl;
  assign exmemAlu     = exmem.alu;
  assign exmemStore   = exmem.store;
  assign exmemPcPlus4 = exmem.pcPlus4;
  assign exmemInstr   = exmem.instr;
  assign exmemDest    = exmem.dest;

  // one data request kind at a time
  assert property (@(posedge CLK) disable iff (!nRST) !(exmem.ctrl.dREN && exmem.ctrl.dWEN));

endmodule

// File: source/memWriteback.sv
/*
  memory and writeback: data request levels, MEM/WB
  register, writeback select, halt flag
*/
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memWriteback import cpuTypesPkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     pipeEn,
  input  logic     dhit,
  input  ctrl_t    exmemCtrl,
  input  word_t    exmemAlu,
  input  word_t    exmemStore,
  input  word_t    exmemPcPlus4,
  input  word_t    exmemInstr,
  input  regBits_t exmemDest,
  input  word_t    dmemload,
  output logic     dmemREN,
  output logic     dmemWEN,
  output word_t    dmemaddr,
  output word_t    dmemstore,
  output logic     wen,
  output regBits_t wsel,
  output word_t    wdat,
  output logic     halt
);
  memwb_t memwb;

  // request levels held until dhit
  assign dmemREN   = exmemCtrl.dREN;
  assign dmemWEN   = exmemCtrl.dWEN;
  assign dmemaddr  = exmemAlu;
  assign dmemstore = exmemStore;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      memwb <= '0;
    else if (pipeEn || dhit)
      memwb <= '{ctrl: exmemCtrl, alu: exmemAlu, load: dmemload, pcPlus4: exmemPcPlus4,
                 instr: exmemInstr, dest: exmemDest};
  end

  assign wen  = memwb.ctrl.wen;
  assign wsel = memwb.dest;
  assign wdat = memwb.ctrl.lui  ? {memwb.instr[15:0], 16'h0} :
                memwb.ctrl.jal  ? memwb.pcPlus4 :
                memwb.ctrl.dREN ? memwb.load : memwb.alu;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      halt <= 1'b0;
    else if (memwb.instr == `HALT_INSTR)
      halt <= 1'b1;  // sticky until reset
  end

  // pending request stays put until memory answers
  assert property (@(posedge CLK) disable iff (!nRST)
    (dmemREN || dmemWEN) && !dhit |=> (dmemREN || dmemWEN) && $stable(dmemaddr));

endmodule

// File: source/datapath.sv
/*
  pipeline top: fetch, decode, execute, memory and
  writeback stages wired to the memory ports
*/
`timescale 1ns/1ps

module datapath import cpuTypesPkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  output word_t imemaddr,
  output logic  imemREN,
  input  word_t imemload,
  input  logic  ihit,
  output logic  dmemREN,
  output logic  dmemWEN,
  output word_t dmemaddr,
  output word_t dmemstore,
  input  word_t dmemload,
  input  logic  dhit,
  output logic  halt
);
  logic     pipeEn, stall, redirect, wen;
  word_t    target, ifidInstr, ifidPcPlus4, wdat;
  ctrl_t    idexCtrl, exmemCtrl;
  word_t    idexInstr, idexPcPlus4, idexRdat1, idexRdat2;
  word_t    exmemAlu, exmemStore, exmemPcPlus4, exmemInstr;
  regBits_t idexDest, exmemDest, wsel;

  assign imemREN = 1'b1;
  // freeze everything while a data access is outstanding
  assign pipeEn  = ihit && !exmemCtrl.dREN && !exmemCtrl.dWEN;

  fetchUnit fetch_i (.*);

  decodeUnit decode_i (.*, .flush(redirect));

  executeUnit execute_i (.*, .memwbWen(wen), .memwbDest(wsel), .memwbValue(wdat));

  memWriteback memWb_i (.*);

endmodule

// File: verification/datapathTb.sv
/*
  testbench for the pipeline top with clock and reset, instruction ROM and
  data memory models with random latency, test program, expected stores
  and the assertions that check them
*/
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapathTb import cpuTypesPkg::*; ();
  localparam int NUM_STORES = 10;
  localparam word_t POISON = 32'h0000_00f0;  // skipped paths store here
  localparam int HALT_TIMEOUT = 3000;

  logic  CLK = 1'b0;
  logic  nRST = 1'b0;
  logic  ihit = 1'b0;
  logic  dhit = 1'b0;
  word_t dmemload = '0;
  word_t imemload, imemaddr, dmemaddr, dmemstore;
  logic  imemREN, dmemREN, dmemWEN, halt;

  word_t prog [128];
  word_t mem [64];
  word_t expAddr [NUM_STORES];
  word_t expData [NUM_STORES];
  word_t lfsr = 32'h0abc_78f7;
  int    iWait = 0;
  int    dWait = 0;
  logic  dBusy = 1'b0;
  int    storeCount = 0;
  int    storeErrors = 0;
  int    otherErrors = 0;
  int    cycles;

  always #4 CLK = ~CLK;

  datapath datapath_i (.*);

  function automatic word_t encodeR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                    logic [4:0] shamt, logic [5:0] funct);
    return {6'h00, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                    logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t encodeJ(logic [5:0] op, logic [25:0] index);
    return {op, index};
  endfunction

  // galois lfsr stepped once per bit
  function automatic int drawBits(int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // ROM read follows the PC
  assign imemload = prog[imemaddr[8:2]];

  // instruction and data memory models
  always @(posedge CLK) begin
    if (!nRST) begin
      ihit  <= 1'b0;
      iWait <= 0;
      dhit  <= 1'b0;
      dBusy <= 1'b0;
      for (int k = 0; k < 64; k++)
        mem[k] <= 32'hc0de_0000 + word_t'(k * 4);  // whole byte address in pattern
    end
    else begin
      if (iWait == 0) begin
        ihit  <= 1'b1;
        iWait <= drawBits(2) % 3;  // 0 to 2 idle cycles
      end
      else begin
        ihit  <= 1'b0;
        iWait <= iWait - 1;
      end
      if (dhit) begin
        dhit  <= 1'b0;
        dBusy <= 1'b0;
      end
      else if (dBusy) begin
        if (dWait == 0) begin
          dhit <= 1'b1;
          if (dmemWEN)
            mem[dmemaddr[7:2]] <= dmemstore;
          else
            dmemload <= mem[dmemaddr[7:2]];
        end
        else
          dWait <= dWait - 1;
      end
      else if (dmemREN || dmemWEN) begin
        dBusy <= 1'b1;
        dWait <= drawBits(2) % 3;  // answer 1 to 3 cycles later
      end
    end
  end

  always @(posedge CLK) begin
    if (nRST && dhit && dmemWEN)
      storeCount <= storeCount + 1;
  end

  // each store matches the next expected one
  assert property (@(posedge CLK) disable iff (!nRST)
    (dhit && dmemWEN) |-> (storeCount < NUM_STORES && dmemaddr == expAddr[storeCount]
                          && dmemstore == expData[storeCount]))
  else begin
    storeErrors++;
    $display("FAILED store %0d: dmemaddr=%h expected %h dmemstore=%h expected %h",
             $sampled(storeCount), $sampled(dmemaddr), expAddr[$sampled(storeCount)],
             $sampled(dmemstore), expData[$sampled(storeCount)]);
  end

  assert property (@(posedge CLK) disable iff (!nRST) !(dmemREN && dmemWEN))
  else begin
    otherErrors++;
    $display("read and write requested in the same cycle");
  end

  assert property (@(posedge CLK) disable iff (!nRST) imemREN)
  else begin
    otherErrors++;
    $display("FAILED imemREN=%h expected 1", $sampled(imemREN));
  end

  assert property (@(posedge CLK) disable iff (!nRST) dmemWEN |-> dmemaddr != POISON)
  else begin
    otherErrors++;
    $display("store from a skipped path reached data memory");
  end

  assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
  else begin
    otherErrors++;
    $display("halt dropped before reset");
  end

  assert property (@(posedge CLK) disable iff (!nRST) halt |-> !(dhit && dmemWEN))
  else begin
    otherErrors++;
    $display("store completed after halt");
  end

  task automatic checkIdle();
    assert (!dmemREN && !dmemWEN && !halt && imemaddr == `PC_INIT)
    else begin
      otherErrors++;
      $display("FAILED idle outputs: dmemREN=%h dmemWEN=%h halt=%h imemaddr=%h",
               dmemREN, dmemWEN, halt, imemaddr);
    end
  endtask

  initial begin
    for (int k = 0; k < 128; k++)
      prog[k] = '0;
    prog[0]  = encodeI(OP_ADDIU, 5'd0, 5'd1, 16'd5);        // r1 = 5
    prog[1]  = encodeI(OP_ADDIU, 5'd1, 5'd2, 16'd3);        // r2 = 8
    prog[2]  = encodeR(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU);    // r3 = 13
    prog[3]  = encodeR(5'd3, 5'd1, 5'd4, 5'd0, FN_SUBU);    // r4 = 8
    prog[4]  = encodeR(5'd4, 5'd3, 5'd5, 5'd0, FN_AND);     // r5 = 8
    prog[5]  = encodeR(5'd5, 5'd1, 5'd6, 5'd0, FN_OR);      // r6 = 13
    prog[6]  = encodeR(5'd1, 5'd6, 5'd7, 5'd0, FN_SLT);     // r7 = 1
    prog[7]  = encodeR(5'd0, 5'd6, 5'd8, 5'd4, FN_SLL);     // r8 = 0xd0
    prog[8]  = encodeI(OP_LUI, 5'd0, 5'd9, 16'h1234);
    prog[9]  = encodeI(OP_ORI, 5'd9, 5'd9, 16'h5678);       // r9 = 0x12345678
    prog[10] = encodeI(OP_SW, 5'd0, 5'd3, 16'h0040);
    prog[11] = encodeI(OP_SW, 5'd0, 5'd4, 16'h0044);
    prog[12] = encodeI(OP_SW, 5'd0, 5'd5, 16'h0048);
    prog[13] = encodeI(OP_SW, 5'd0, 5'd6, 16'h004c);
    prog[14] = encodeI(OP_SW, 5'd0, 5'd7, 16'h0050);
    prog[15] = encodeI(OP_SW, 5'd0, 5'd8, 16'h0054);
    prog[16] = encodeI(OP_SW, 5'd0, 5'd9, 16'h0058);
    prog[17] = encodeI(OP_LW, 5'd0, 5'd10, 16'h0010);       // fill word at 0x10
    prog[18] = encodeI(OP_ADDIU, 5'd10, 5'd11, 16'd7);      // load-use
    prog[19] = encodeI(OP_SW, 5'd0, 5'd11, 16'h005c);
    prog[20] = encodeI(OP_BEQ, 5'd1, 5'd1, 16'd2);          // taken to 23
    prog[21] = encodeI(OP_SW, 5'd0, 5'd0, POISON[15:0]);
    prog[22] = encodeI(OP_SW, 5'd0, 5'd0, POISON[15:0]);
    prog[23] = encodeI(OP_BNE, 5'd1, 5'd1, 16'd1);          // not taken
    prog[24] = encodeI(OP_ADDIU, 5'd0, 5'd12, 16'h0021);
    prog[25] = encodeI(OP_SW, 5'd0, 5'd12, 16'h0060);
    prog[26] = encodeJ(OP_J, 26'd28);
    prog[27] = encodeI(OP_SW, 5'd0, 5'd0, POISON[15:0]);
    prog[28] = encodeJ(OP_JAL, 26'd31);                     // r31 = 0x74
    prog[29] = encodeI(OP_SW, 5'd0, 5'd0, POISON[15:0]);
    prog[30] = encodeI(OP_SW, 5'd0, 5'd0, POISON[15:0]);
    prog[31] = encodeI(OP_SW, 5'd0, 5'd31, 16'h0064);
    prog[32] = `HALT_INSTR;

    expAddr = '{32'h40, 32'h44, 32'h48, 32'h4c, 32'h50,
                32'h54, 32'h58, 32'h5c, 32'h60, 32'h64};
    expData = '{32'd13, 32'd8, 32'd8, 32'd13, 32'd1,
                32'hd0, 32'h1234_5678, 32'hc0de_0017, 32'h21, 32'h74};

    // reset held for two cycles
    for (int k = 0; k < 2; k++) begin
      @(negedge CLK);
      checkIdle();
    end
    @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    checkIdle();

    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(posedge CLK);
      cycles++;
    end
    if (!halt) begin
      otherErrors++;
      $display("timeout: halt never rose");
    end

    // let any late store show up
    cycles = 0;
    while (cycles < 20) begin
      @(posedge CLK);
      cycles++;
    end
    assert (storeCount == NUM_STORES)
    else begin
      otherErrors++;
      $display("FAILED storeCount=%h expected %h", storeCount, NUM_STORES);
    end

    $display("store errors: %0d, other errors: %0d", storeErrors, otherErrors);
    if (storeErrors == 0 && otherErrors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: list.f
+incdir+source
source/cpuTypesPkg.sv
source/fetchUnit.sv
source/registerFile.sv
source/controlDecoder.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memWriteback.sv
source/datapath.sv
verification/datapathTb.sv

// File: run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module datapathTb \
  -o datapathSim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/datapathSim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "All checks passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see sim.log"
  exit 1
fi
